// File: hdl/addr_range_ctr.sv
module addr_range_ctr (
    input  logic                    clk,
    input  logic                    reset,
    input  crypto_pkg::range_ctl_t  ctl,
    input  crypto_pkg::word_t       bound,
    output crypto_pkg::word_t       addr,
    output logic                    done
);
    import crypto_pkg::*;

    word_t limit;

    always_ff @(posedge clk)
    begin
        if (reset)
            addr <= '0;
        else if (ctl.init)
            addr <= bound;
        else if (ctl.inc)
            addr <= addr + ADDR_STEP;
    end

    // end address is exclusive
    always_ff @(posedge clk)
    begin
        if (reset)
            limit <= '0;
        else if (ctl.limit_init)
            limit <= bound;
    end

    assign done = (addr >= limit);

endmodule

// File: hdl/crypto_control.sv
module crypto_control (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   irq_pnd,
    input  crypto_pkg::cmd_t       cmd,
    input  crypto_pkg::cpu_regs_t  regs,
    input  crypto_pkg::word_t      sm_data,
    input  crypto_pkg::word_t      sm_prev_id,
    input  logic                   sm_data_select_valid,
    input  logic                   sm_key_select_valid,
    output logic                   busy,
    output crypto_pkg::sm_req_t    sm_request,
    output crypto_pkg::word_t      sm_data_select,
    output crypto_pkg::word_t      sm_key_select,
    output crypto_pkg::mem_bus_t   mem,
    output crypto_pkg::reg_wb_t    wb,
    output crypto_pkg::status_t    status
);
    import crypto_pkg::*;

    range_ctl_t   range_ctl;
    result_kind_t result_kind;
    logic         sm_valid;
    logic         range_done;
    logic         mem_en;
    byte_en_t     mem_wr;
    word_t        mem_addr;

    // clearing is the only memory write, so data is always zero
    assign mem = '{en: mem_en, wr: mem_wr, addr: mem_addr, data: '0};

    crypto_fsm i_crypto_fsm (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .irq_pnd     (irq_pnd),
        .cmd         (cmd),
        .sm_valid    (sm_valid),
        .range_done  (range_done),
        .busy        (busy),
        .sm_request  (sm_request),
        .range_ctl   (range_ctl),
        .mem_en      (mem_en),
        .mem_wr      (mem_wr),
        .result_kind (result_kind),
        .status      (status)
    );

    // range bounds come straight from the SM table answer
    addr_range_ctr i_addr_range_ctr (
        .clk   (clk),
        .reset (reset),
        .ctl   (range_ctl),
        .bound (sm_data),
        .addr  (mem_addr),
        .done  (range_done)
    );

    sm_select i_sm_select (
        .clk               (clk),
        .reset             (reset),
        .cmd               (cmd),
        .regs              (regs),
        .data_select_valid (sm_data_select_valid),
        .key_select_valid  (sm_key_select_valid),
        .data_select       (sm_data_select),
        .key_select        (sm_key_select),
        .sm_valid          (sm_valid)
    );

    result_reg i_result_reg (
        .clk        (clk),
        .reset      (reset),
        .kind       (result_kind),
        .cmd        (cmd),
        .regs       (regs),
        .sm_data    (sm_data),
        .sm_prev_id (sm_prev_id),
        .wb         (wb)
    );

endmodule

// File: hdl/crypto_fsm.sv
module crypto_fsm (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic                      irq_pnd,
    input  crypto_pkg::cmd_t          cmd,
    input  logic                      sm_valid,
    input  logic                      range_done,
    output logic                      busy,
    output crypto_pkg::sm_req_t       sm_request,
    output crypto_pkg::range_ctl_t    range_ctl,
    output logic                      mem_en,
    output crypto_pkg::byte_en_t      mem_wr,
    output crypto_pkg::result_kind_t  result_kind,
    output crypto_pkg::status_t       status
);
    import crypto_pkg::*;

    crypto_state_t state;
    crypto_state_t next_state;
    logic          irq_abort;

    // only the multi-cycle part of a command can be interrupted
    assign irq_abort = irq_pnd &&
                       !(state inside {IDLE, CHECK_SM, FAIL, SUCCESS, IRQ_FAIL});

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = IDLE;
        if (irq_abort)
        begin
            next_state = IRQ_FAIL;
        end
        else
        begin
            case (state)
                IDLE:
                    next_state = start ? CHECK_SM : IDLE;
                CHECK_SM:
                begin
                    if (!sm_valid)
                        next_state = FAIL;
                    else if (cmd.id || cmd.id_prev)
                        next_state = SUCCESS;
                    else if (cmd.disable_sm)
                        next_state = CLEAR_CODE_INIT1;
                    else
                        next_state = FAIL;
                end
                CLEAR_CODE_INIT1:
                    next_state = CLEAR_CODE_INIT2;
                CLEAR_CODE_INIT2:
                    next_state = CLEAR_CODE;
                CLEAR_CODE:
                    next_state = range_done ? CLEAR_DATA_INIT1 : CLEAR_CODE;
                CLEAR_DATA_INIT1:
                    next_state = CLEAR_DATA_INIT2;
                CLEAR_DATA_INIT2:
                    next_state = CLEAR_DATA;
                CLEAR_DATA:
                    next_state = range_done ? SUCCESS : CLEAR_DATA;
                SUCCESS:
                    next_state = cmd.disable_sm ? WAIT : IDLE;
                FAIL, IRQ_FAIL, WAIT:
                    next_state = IDLE;
                default:
                    next_state = IDLE;
            endcase
        end
    end

    // control decode on the state being entered
    always_comb
    begin
        busy        = 1'b1;
        sm_request  = REQ_NONE;
        range_ctl   = '0;
        mem_en      = 1'b0;
        mem_wr      = '0;
        result_kind = RES_NONE;
        status      = '0;

        case (next_state)
            IDLE:
                busy = 1'b0;
            CLEAR_CODE_INIT1:
            begin
                sm_request     = REQ_PUB_START;
                range_ctl.init = 1'b1;
            end
            CLEAR_CODE_INIT2:
            begin
                sm_request           = REQ_PUB_END;
                range_ctl.limit_init = 1'b1;
            end
            CLEAR_DATA_INIT1:
            begin
                sm_request     = REQ_SEC_START;
                range_ctl.init = 1'b1;
            end
            CLEAR_DATA_INIT2:
            begin
                sm_request           = REQ_SEC_END;
                range_ctl.limit_init = 1'b1;
            end
            CLEAR_CODE, CLEAR_DATA:
            begin
                mem_en        = 1'b1;
                mem_wr        = BYTE_EN_WORD;
                range_ctl.inc = 1'b1;
            end
            FAIL:
            begin
                result_kind = RES_FAIL;
                status.wr   = 1'b1;
            end
            IRQ_FAIL:
            begin
                // z tells an abort apart from a failed check
                result_kind = RES_FAIL;
                status.wr   = 1'b1;
                status.z    = 1'b1;
            end
            SUCCESS:
            begin
                sm_request  = REQ_ID;
                result_kind = RES_SUCCESS;
                status.wr   = 1'b1;
            end
            default:
            begin
            end
        endcase
    end

endmodule

// File: hdl/crypto_pkg.sv
package crypto_pkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] reg_sel_t;
    typedef logic [1:0]  byte_en_t;

    // byte step between consecutive words
    localparam word_t    ADDR_STEP    = 16'd2;
    // one-hot register selects
    localparam reg_sel_t DEST_R15     = 16'h8000;
    localparam reg_sel_t DEST_PC      = 16'h0001;
    localparam byte_en_t BYTE_EN_WORD = 2'b11;

    // disable is a keyword, hence the suffix
    typedef struct packed {
        logic id;
        logic id_prev;
        logic disable_sm;
    } cmd_t;

    typedef struct packed {
        word_t pc;
        word_t r15;
    } cpu_regs_t;

    typedef enum logic [2:0] {
        REQ_NONE,
        REQ_ID,
        REQ_PUB_START,
        REQ_PUB_END,
        REQ_SEC_START,
        REQ_SEC_END
    } sm_req_t;

    typedef struct packed {
        logic     en;
        byte_en_t wr;
        word_t    addr;
        word_t    data;
    } mem_bus_t;

    typedef struct packed {
        logic     write;
        reg_sel_t dest;
        word_t    data;
    } reg_wb_t;

    typedef struct packed {
        logic wr;
        logic z;
    } status_t;

    typedef struct packed {
        logic init;
        logic limit_init;
        logic inc;
    } range_ctl_t;

    typedef enum logic [1:0] {
        RES_NONE,
        RES_FAIL,
        RES_SUCCESS
    } result_kind_t;

    typedef enum logic [3:0] {
        IDLE,
        CHECK_SM,
        CLEAR_CODE_INIT1,
        CLEAR_CODE_INIT2,
        CLEAR_CODE,
        CLEAR_DATA_INIT1,
        CLEAR_DATA_INIT2,
        CLEAR_DATA,
        FAIL,
        IRQ_FAIL,
        SUCCESS,
        WAIT
    } crypto_state_t;

endpackage

// File: hdl/result_reg.sv
module result_reg (
    input  logic                      clk,
    input  logic                      reset,
    input  crypto_pkg::result_kind_t  kind,
    input  crypto_pkg::cmd_t          cmd,
    input  crypto_pkg::cpu_regs_t     regs,
    input  crypto_pkg::word_t         sm_data,
    input  crypto_pkg::word_t         sm_prev_id,
    output crypto_pkg::reg_wb_t       wb
);
    import crypto_pkg::*;

    word_t success_data;

    always_comb
    begin
        if (cmd.id)
            success_data = sm_data;
        else if (cmd.id_prev)
            success_data = sm_prev_id;
        else
            success_data = regs.r15;
    end

    always_ff @(posedge clk)
    begin
        if (reset || kind == RES_NONE)
        begin
            wb <= '0;
        end
        else
        begin
            wb.write <= 1'b1;
            if (kind == RES_FAIL)
            begin
                wb.dest <= DEST_R15;
                wb.data <= '0;
            end
            else
            begin
                // disable jumps back through the PC
                wb.dest <= cmd.disable_sm ? DEST_PC : DEST_R15;
                wb.data <= success_data;
            end
        end
    end

endmodule

// File: hdl/sm_select.sv
module sm_select (
    input  logic                   clk,
    input  logic                   reset,
    input  crypto_pkg::cmd_t       cmd,
    input  crypto_pkg::cpu_regs_t  regs,
    input  logic                   data_select_valid,
    input  logic                   key_select_valid,
    output crypto_pkg::word_t      data_select,
    output crypto_pkg::word_t      key_select,
    output logic                   sm_valid
);

    logic data_needed;
    logic key_needed;

    // lookup by address in r15, otherwise the calling SM
    assign data_select = cmd.id ? regs.r15 : regs.pc;
    assign key_select  = regs.pc;

    // previous-caller needs no SM at all
    assign data_needed = cmd.id;
    assign key_needed  = cmd.disable_sm;

    always_ff @(posedge clk)
    begin
        if (reset)
            sm_valid <= 1'b0;
        else
            sm_valid <= (!data_needed || data_select_valid) &&
                        (!key_needed || key_select_valid);
    end

endmodule

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f \
    --top-module tb_crypto_control \
    -o sim_crypto_control

./obj_dir/sim_crypto_control | tee sim.log

grep -q "=== PASS ===" sim.log

// File: src.f
hdl/crypto_pkg.sv
hdl/addr_range_ctr.sv
hdl/sm_select.sv
hdl/result_reg.sv
hdl/crypto_fsm.sv
hdl/crypto_control.sv
verification/crypto_control_sva.sv
verification/crypto_checker.sv
verification/tb_crypto_control.sv

// File: verification/crypto_checker.sv
module crypto_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   irq_test,
    input  crypto_pkg::cmd_t       cmd,
    input  crypto_pkg::cpu_regs_t  regs,
    input  crypto_pkg::word_t      sm_prev_id,
    input  logic                   data_valid,
    input  logic                   key_valid,
    input  crypto_pkg::word_t      exp_id,
    input  crypto_pkg::word_t      exp_pub_start,
    input  crypto_pkg::word_t      exp_pub_end,
    input  crypto_pkg::word_t      exp_sec_start,
    input  crypto_pkg::word_t      exp_sec_end,
    input  logic                   busy,
    input  crypto_pkg::sm_req_t    sm_request,
    input  crypto_pkg::word_t      sm_data_select,
    input  crypto_pkg::word_t      sm_key_select,
    input  crypto_pkg::mem_bus_t   mem,
    input  crypto_pkg::reg_wb_t    wb,
    input  crypto_pkg::status_t    status,
    output int                     tests_done,
    output int                     errors
);
    import crypto_pkg::*;

    word_t     expected_addrs[$];
    word_t     written_addrs[$];
    cmd_t      cmd_q;
    cpu_regs_t regs_q;
    logic      dv_q;
    logic      kv_q;
    logic      irq_q;
    word_t     id_q;
    word_t     prev_q;
    logic      in_cmd = 1'b0;
    logic      reset_checked = 1'b0;
    int        cycles = 0;
    int        status_cycle = -1;
    logic      status_z = 1'b0;
    int        test_errors = 0;

    initial
    begin
        tests_done = 0;
        errors     = 0;
    end

    // expected {z, write, dest, data} for a finished command
    function automatic logic [33:0] ref_result(cmd_t c, logic dv, logic kv, logic irq,
                                               word_t id, word_t prev, word_t r15);
        reg_wb_t w;
        logic    z;
        logic    ok;
        w.write = 1'b1;
        w.dest  = DEST_R15;
        w.data  = '0;
        z       = 1'b0;
        ok      = !((c.id && !dv) || (c.disable_sm && !kv)) &&
                  (c.id || c.id_prev || c.disable_sm);
        if (irq)
        begin
            z = 1'b1;
        end
        else if (ok)
        begin
            if (c.id)
                w.data = id;
            else if (c.id_prev)
                w.data = prev;
            else
            begin
                w.dest = DEST_PC;
                w.data = r15;
            end
        end
        return {z, w};
    endfunction

    function automatic string cmd_name(cmd_t c, logic irq);
        if (irq)
            return "disable with interrupt";
        if (c.id)
            return "identity lookup";
        if (c.id_prev)
            return "previous caller";
        return "disable";
    endfunction

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want)
        begin
            $display("Mismatch %s: got %h expected %h", name, got, want);
            test_errors++;
        end
    endtask

    task automatic report(string what);
        $display("%s", what);
        test_errors++;
    endtask

    always @(negedge clk)
    begin
        logic [33:0] exp;
        logic        full_run;
        if (reset)
        begin
            in_cmd = 1'b0;
        end
        else if (!reset_checked)
        begin
            test_errors = 0;
            if (busy || wb.write || mem.en || status.wr || sm_request != REQ_NONE)
                report("outputs active right after reset");
            $display("test %0d reset state: %s", tests_done + 1,
                     test_errors == 0 ? "ok" : "failed");
            errors += test_errors;
            tests_done++;
            reset_checked = 1'b1;
        end
        else
        begin
            if (start && !in_cmd)
            begin
                cmd_q  = cmd;
                regs_q = regs;
                dv_q   = data_valid;
                kv_q   = key_valid;
                irq_q  = irq_test;
                id_q   = exp_id;
                prev_q = sm_prev_id;
                in_cmd = 1'b1;
                cycles = 0;
                status_cycle = -1;
                test_errors  = 0;
                expected_addrs.delete();
                written_addrs.delete();
                // lookup asks about the SM owning r15, disable about the caller
                if (cmd.id)
                    compare_value("sm_data_select", 32'(sm_data_select), 32'(regs.r15));
                else if (cmd.disable_sm)
                    compare_value("sm_data_select", 32'(sm_data_select), 32'(regs.pc));
                compare_value("sm_key_select", 32'(sm_key_select), 32'(regs.pc));
                if (cmd.disable_sm && key_valid)
                begin
                    for (word_t a = exp_pub_start; a < exp_pub_end; a += ADDR_STEP)
                        expected_addrs.push_back(a);
                    for (word_t a = exp_sec_start; a < exp_sec_end; a += ADDR_STEP)
                        expected_addrs.push_back(a);
                end
            end
            else if (in_cmd)
            begin
                cycles++;
            end

            if (mem.en)
            begin
                if (!in_cmd)
                    report("memory write outside a command");
                written_addrs.push_back(mem.addr);
                compare_value("mem.wr", 32'(mem.wr), 32'(BYTE_EN_WORD));
                compare_value("mem.data", 32'(mem.data), 32'h0);
            end

            if (status.wr)
            begin
                status_cycle = cycles;
                status_z     = status.z;
            end

            if (wb.write && !in_cmd)
            begin
                report("register writeback with no command running");
            end
            else if (wb.write)
            begin
                exp = ref_result(cmd_q, dv_q, kv_q, irq_q, id_q, prev_q, regs_q.r15);
                compare_value("wb.dest", 32'(wb.dest), 32'(exp[31:16]));
                compare_value("wb.data", 32'(wb.data), 32'(exp[15:0]));
                compare_value("status.z", 32'(status_z), 32'(exp[33]));
                if (status_cycle != cycles - 1)
                    report("status flag not written in the cycle before the writeback");
                if (!irq_q && exp[31:16] != DEST_PC && cycles != 2)
                    report($sformatf("writeback came %0d cycles after start instead of 2",
                                     cycles));
                // an abort may stop anywhere, a full clear must hit every word
                full_run = !irq_q;
                if (written_addrs.size() > expected_addrs.size())
                    report("more memory writes than the SM ranges hold");
                else if (full_run && written_addrs.size() != expected_addrs.size())
                    compare_value("write count", written_addrs.size(),
                                  expected_addrs.size());
                foreach (written_addrs[i])
                    if (i < expected_addrs.size())
                        compare_value("mem.addr", 32'(written_addrs[i]),
                                      32'(expected_addrs[i]));
                $display("test %0d %s: %s", tests_done + 1, cmd_name(cmd_q, irq_q),
                         test_errors == 0 ? "ok" : "failed");
                errors += test_errors;
                tests_done++;
                in_cmd = 1'b0;
            end
        end
    end

endmodule

// File: verification/crypto_control_sva.sv
module crypto_control_sva (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  crypto_pkg::cmd_t      cmd,
    input  logic                  busy,
    input  crypto_pkg::mem_bus_t  mem,
    input  crypto_pkg::reg_wb_t   wb
);

    // writeback is a single-cycle strobe
    wb_single_cycle: assert property (@(posedge clk) disable iff (reset)
        wb.write |=> !wb.write)
        else $error("register writeback high for two cycles in a row");

    mem_en_needs_busy: assert property (@(posedge clk) disable iff (reset)
        mem.en |-> busy)
        else $error("memory write while the controller is idle");

    start_one_command: assert property (@(posedge clk) disable iff (reset)
        start |-> $onehot(cmd))
        else $error("start without exactly one command strobe");

endmodule

bind crypto_control crypto_control_sva i_crypto_control_sva (.*);

// File: verification/tb_crypto_control.sv
module tb_crypto_control;
    import crypto_pkg::*;

    localparam int NUM_SM     = 4;
    localparam int WAIT_LIMIT = 400;

    logic      clk;
    logic      reset;
    logic      start;
    logic      irq_pnd;
    cmd_t      cmd;
    cpu_regs_t regs;
    word_t     sm_data;
    word_t     sm_prev_id;
    logic      data_valid;
    logic      key_valid;
    logic      busy;
    sm_req_t   sm_request;
    word_t     sm_data_select;
    word_t     sm_key_select;
    mem_bus_t  mem;
    reg_wb_t   wb;
    status_t   status;

    // SM table contents
    word_t sm_id     [NUM_SM];
    word_t pub_start [NUM_SM];
    word_t pub_end   [NUM_SM];
    word_t sec_start [NUM_SM];
    word_t sec_end   [NUM_SM];

    logic force_invalid;
    logic irq_test;
    int   cur_sm;
    int   tests_done;
    int   check_errors;
    logic timed_out;

    crypto_control i_crypto_control (
        .clk                  (clk),
        .reset                (reset),
        .start                (start),
        .irq_pnd              (irq_pnd),
        .cmd                  (cmd),
        .regs                 (regs),
        .sm_data              (sm_data),
        .sm_prev_id           (sm_prev_id),
        .sm_data_select_valid (data_valid),
        .sm_key_select_valid  (key_valid),
        .busy                 (busy),
        .sm_request           (sm_request),
        .sm_data_select       (sm_data_select),
        .sm_key_select        (sm_key_select),
        .mem                  (mem),
        .wb                   (wb),
        .status               (status)
    );

    crypto_checker i_crypto_checker (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .irq_test       (irq_test),
        .cmd            (cmd),
        .regs           (regs),
        .sm_prev_id     (sm_prev_id),
        .data_valid     (data_valid),
        .key_valid      (key_valid),
        .exp_id         (sm_id[cur_sm]),
        .exp_pub_start  (pub_start[cur_sm]),
        .exp_pub_end    (pub_end[cur_sm]),
        .exp_sec_start  (sec_start[cur_sm]),
        .exp_sec_end    (sec_end[cur_sm]),
        .busy           (busy),
        .sm_request     (sm_request),
        .sm_data_select (sm_data_select),
        .sm_key_select  (sm_key_select),
        .mem            (mem),
        .wb             (wb),
        .status         (status),
        .tests_done     (tests_done),
        .errors         (check_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int find_owner(word_t addr);
        for (int i = 0; i < NUM_SM; i++)
            if (addr >= pub_start[i] && addr < pub_end[i])
                return i;
        return -1;
    endfunction

    // behavioural SM table, answers in the same cycle
    always_comb
    begin
        int data_owner;
        int key_owner;
        data_owner = find_owner(sm_data_select);
        key_owner  = find_owner(sm_key_select);
        data_valid = (data_owner >= 0) && !force_invalid;
        key_valid  = (key_owner >= 0) && !force_invalid;
        sm_data    = '0;
        if (key_owner >= 0)
        begin
            case (sm_request)
                REQ_PUB_START: sm_data = pub_start[key_owner];
                REQ_PUB_END:   sm_data = pub_end[key_owner];
                REQ_SEC_START: sm_data = sec_start[key_owner];
                REQ_SEC_END:   sm_data = sec_end[key_owner];
                default:       sm_data = '0;
            endcase
        end
        if (sm_request == REQ_ID && data_owner >= 0)
            sm_data = sm_id[data_owner];
    end

    task automatic build_table();
        for (int i = 0; i < NUM_SM; i++)
        begin
            sm_id[i]     = word_t'((i + 1) * 16 + $urandom % 16);
            pub_start[i] = word_t'(16'h1000 * (i + 1) + 2 * ($urandom % 32));
            pub_end[i]   = word_t'(pub_start[i] + 2 * (1 + $urandom % 6));
            sec_start[i] = word_t'(16'h8000 + 16'h1000 * i + 2 * ($urandom % 32));
            sec_end[i]   = word_t'(sec_start[i] + 2 * (1 + $urandom % 6));
        end
    endtask

    function automatic word_t addr_in_sm(int i);
        return word_t'(pub_start[i] + 2 * ($urandom % ((pub_end[i] - pub_start[i]) / 2)));
    endfunction

    task automatic run_command(cmd_t c, word_t pc_val, word_t r15_val, logic with_irq);
        int start_count;
        int waited;
        int owner;
        @(posedge clk);
        #1;
        owner       = find_owner(c.id ? r15_val : pc_val);
        cur_sm      = (owner >= 0) ? owner : 0;
        cmd         = c;
        regs.pc     = pc_val;
        regs.r15    = r15_val;
        irq_test    = with_irq;
        start_count = tests_done;
        start       = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        if (with_irq)
        begin
            waited = 0;
            while (!mem.en && waited < WAIT_LIMIT)
            begin
                @(negedge clk);
                waited++;
            end
            if (waited >= WAIT_LIMIT)
                note_timeout("first memory write");
            @(posedge clk);
            #1;
            irq_pnd = 1'b1;
            @(posedge clk);
            #1;
            irq_pnd = 1'b0;
        end
        waited = 0;
        while (tests_done == start_count && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT)
            note_timeout("register writeback");
        waited = 0;
        while (busy && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT)
            note_timeout("controller to become idle");
        @(posedge clk);
        #1;
        cmd = '0;
    endtask

    task automatic note_timeout(string what);
        $display("timeout waiting for %s", what);
        timed_out = 1'b1;
    endtask

    initial
    begin
        int   seed;
        cmd_t c_id;
        cmd_t c_prev;
        cmd_t c_dis;
        seed          = $urandom(48);
        reset         = 1'b1;
        start         = 1'b0;
        irq_pnd       = 1'b0;
        cmd           = '0;
        regs          = '0;
        sm_prev_id    = '0;
        force_invalid = 1'b0;
        irq_test      = 1'b0;
        cur_sm        = 0;
        timed_out     = 1'b0;
        c_id          = '{id: 1'b1, id_prev: 1'b0, disable_sm: 1'b0};
        c_prev        = '{id: 1'b0, id_prev: 1'b1, disable_sm: 1'b0};
        c_dis         = '{id: 1'b0, id_prev: 1'b0, disable_sm: 1'b1};
        build_table();
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < NUM_SM; i++)
            if (!timed_out)
                run_command(c_id, word_t'($urandom), addr_in_sm(i), 1'b0);

        // previous caller with both valid levels low
        force_invalid = 1'b1;
        sm_prev_id    = word_t'($urandom);
        if (!timed_out)
            run_command(c_prev, addr_in_sm(0), word_t'($urandom), 1'b0);
        if (!timed_out)
            run_command(c_id, word_t'($urandom), addr_in_sm(1), 1'b0);
        if (!timed_out)
            run_command(c_dis, addr_in_sm(2), word_t'($urandom), 1'b0);
        force_invalid = 1'b0;
        if (!timed_out)
            run_command(c_id, word_t'($urandom), 16'hf000, 1'b0);

        for (int i = 0; i < NUM_SM; i++)
            if (!timed_out)
                run_command(c_dis, addr_in_sm(i), word_t'($urandom), 1'b0);
        if (!timed_out)
            run_command(c_dis, addr_in_sm(3), word_t'($urandom), 1'b1);

        repeat (3) @(posedge clk);
        $display("tests run %0d, errors %0d", tests_done, check_errors + int'(timed_out));
        if (check_errors == 0 && !timed_out)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule
